/* logic/mpu_pkg.sv */
`default_nettype none

package mpu_pkg;

	// ========================================
	// bus widths
	// ========================================
	localparam int ADR_W   = 32;
	localparam int DAT_W   = 32;
	localparam int SEL_W   = 4;     // one select per byte lane
	localparam int CAUSE_W = 9;
	localparam int FRAME_W = 16;    // frame number replaces adr[31:16]
	localparam int NUM_IRQ = 31;    // sources 1 to 31, source 0 is "nothing"

	typedef logic [ADR_W-1:0]   adr_t;
	typedef logic [DAT_W-1:0]   dat_t;
	typedef logic [SEL_W-1:0]   sel_t;
	typedef logic [CAUSE_W-1:0] cause_t;   // low 5 bits carry the source number
	typedef logic [FRAME_W-1:0] frame_t;

	// ========================================
	// page map
	// ========================================
	// upper address nibble picks one of the entries
	localparam int MAP_ENTRIES = 16;
	localparam int MAP_IDX_W   = $clog2(MAP_ENTRIES);

	// ========================================
	// i/o windows
	// ========================================
	// compared against physical adr[31:16]
	// both sit at an identity frame so they stay reachable after reset
	localparam frame_t PIC_BASE = 16'hF000;   // entry 15
	localparam frame_t MAP_BASE = 16'hE000;   // entry 14, word i is map entry i

	// controller register word offsets, adr[3:2]
	localparam logic [1:0] PIC_MASK_OFS  = 2'd0;   // enable per source
	localparam logic [1:0] PIC_EDGE_OFS  = 2'd1;   // 1 = edge, 0 = level
	localparam logic [1:0] PIC_PEND_OFS  = 2'd2;   // write 1 to clear an edge
	localparam logic [1:0] PIC_CAUSE_OFS = 2'd3;   // read only

	// routing stage
	typedef enum logic [1:0] {
		RT_IDLE,   // waiting on stage 1
		RT_BUS,    // external cycle running
		RT_RESP    // response held for the core
	} route_state_e;

endpackage

`default_nettype wire

/* logic/mpu_page_map.sv */
`timescale 1ns/1ps
`default_nettype none

module mpu_page_map (
	input  wire                            clk_i,
	input  wire                            arst_n_i,
	input  wire  mpu_pkg::dat_t            pcr_i,         // bit 31 turns paging on
	// core request
	input  wire                            req_valid_i,
	output logic                           req_ready_o,
	input  wire                            req_wr_i,
	input  wire                            req_fetch_i,
	input  wire  mpu_pkg::sel_t            req_sel_i,
	input  wire  mpu_pkg::adr_t            req_adr_i,
	input  wire  mpu_pkg::dat_t            req_dat_i,
	// translated request to the routing stage
	output logic                           s1_valid_o,
	input  wire                            s1_ready_i,
	output logic                           s1_wr_o,
	output logic                           s1_fetch_o,
	output mpu_pkg::sel_t                  s1_sel_o,
	output mpu_pkg::adr_t                  s1_adr_o,
	output mpu_pkg::dat_t                  s1_dat_o,
	// table access from the map window
	input  wire                            map_we_i,
	input  wire  [mpu_pkg::MAP_IDX_W-1:0]  map_idx_i,
	input  wire  mpu_pkg::frame_t          map_wdat_i,
	output mpu_pkg::frame_t                map_rdat_o
);
	import mpu_pkg::*;

	frame_t               map_q [MAP_ENTRIES];   // frame per upper nibble
	logic                 live_q;                // out of reset
	logic                 load;                  // request taken this edge
	logic                 pg_on;
	logic [MAP_IDX_W-1:0] ent;
	adr_t                 padr;                  // physical address

	// ========================================
	// translation
	// ========================================
	assign pg_on = pcr_i[31];
	assign ent   = req_adr_i[ADR_W-1 -: MAP_IDX_W];

	// frame replaces the upper half, offset passes through
	assign padr = pg_on ? {map_q[ent], req_adr_i[ADR_W-FRAME_W-1:0]} : req_adr_i;

	assign map_rdat_o = map_q[map_idx_i];   // combinational read

	// table starts as identity, entry i -> frame i*4096
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < MAP_ENTRIES; i++)
				map_q[i] <= {MAP_IDX_W'(i), {(FRAME_W-MAP_IDX_W){1'b0}}};
		end else if (map_we_i) begin
			map_q[map_idx_i] <= map_wdat_i;
		end
	end

	// ========================================
	// stage 1 slot
	// ========================================
	// slot refills on the same edge it drains
	assign req_ready_o = live_q & (~s1_valid_o | s1_ready_i);
	assign load        = req_valid_i & req_ready_o;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			live_q     <= 1'b0;
			s1_valid_o <= 1'b0;
		end else begin
			live_q <= 1'b1;
			if (load)
				s1_valid_o <= 1'b1;
			else if (s1_ready_i)
				s1_valid_o <= 1'b0;   // drained with nothing behind it
		end
	end

	// payload, only moves on a load
	always_ff @(posedge clk_i) begin
		if (load) begin
			s1_wr_o    <= req_wr_i;
			s1_fetch_o <= req_fetch_i;
			s1_sel_o   <= req_sel_i;
			s1_adr_o   <= padr;
			s1_dat_o   <= req_dat_i;
		end
	end

	// stalled slot keeps its contents until the routing stage takes it
	a_s1_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(s1_valid_o && !s1_ready_i) |=>
			(s1_valid_o && $stable({s1_wr_o, s1_fetch_o, s1_sel_o, s1_adr_o, s1_dat_o})));

endmodule

`default_nettype wire

/* logic/mpu_pic.sv */
`timescale 1ns/1ps
`default_nettype none

module mpu_pic (
	input  wire                          clk_i,
	input  wire                          arst_n_i,
	input  wire  [mpu_pkg::NUM_IRQ:1]    irq_lines_i,   // sources 1 to 31
	// register port, decoded by the routing stage
	input  wire                          cs_i,
	input  wire                          wr_i,
	input  wire  [1:0]                   idx_i,
	input  wire  mpu_pkg::dat_t          wdat_i,
	output mpu_pkg::dat_t                rdat_o,
	// to the core
	output logic                         irq_o,
	output mpu_pkg::cause_t              cause_o
);
	import mpu_pkg::*;

	logic [NUM_IRQ:1] sync1_q;       // first sync flop
	logic [NUM_IRQ:1] sync2_q;       // synchronized lines
	logic [NUM_IRQ:1] prev_q;        // last cycle, for edge detect
	logic [NUM_IRQ:1] mask_q;        // 1 = enabled
	logic [NUM_IRQ:1] edge_sel_q;    // 1 = edge, 0 = level
	logic [NUM_IRQ:1] edge_pend_q;   // latched edges
	logic [NUM_IRQ:1] rise;
	logic [NUM_IRQ:1] clr;
	logic [NUM_IRQ:1] pend;
	logic [NUM_IRQ:1] active;
	logic             wr_mask;
	logic             wr_edge;
	logic             wr_pend;
	cause_t           next_cause;

	// ========================================
	// register writes
	// ========================================
	assign wr_mask = cs_i & wr_i & (idx_i == PIC_MASK_OFS);
	assign wr_edge = cs_i & wr_i & (idx_i == PIC_EDGE_OFS);
	assign wr_pend = cs_i & wr_i & (idx_i == PIC_PEND_OFS);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mask_q     <= '0;   // everything disabled
			edge_sel_q <= '0;   // everything level
		end else begin
			if (wr_mask)
				mask_q <= wdat_i[NUM_IRQ:1];
			if (wr_edge)
				edge_sel_q <= wdat_i[NUM_IRQ:1];
		end
	end

	// ========================================
	// input sync and pending
	// ========================================
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q  <= '0;
		end else begin
			sync1_q <= irq_lines_i;
			sync2_q <= sync1_q;
			prev_q  <= sync2_q;
		end
	end

	assign rise = sync2_q & ~prev_q & edge_sel_q;          // edge sources only
	assign clr  = wr_pend ? wdat_i[NUM_IRQ:1] : '0;        // write one to clear

	// a new edge wins over a clear on the same cycle
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			edge_pend_q <= '0;
		else
			edge_pend_q <= (edge_pend_q & ~clr) | rise;
	end

	// level sources simply follow the synchronized line
	assign pend   = (edge_sel_q & edge_pend_q) | (~edge_sel_q & sync2_q);
	assign active = pend & mask_q;

	// lowest numbered active source wins
	always_comb begin
		next_cause = '0;
		for (int i = NUM_IRQ; i >= 1; i--) begin
			if (active[i])
				next_cause = cause_t'(i);
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			irq_o   <= 1'b0;
			cause_o <= '0;
		end else begin
			irq_o   <= |active;
			cause_o <= next_cause;   // 0 when nothing is active
		end
	end

	// ========================================
	// register reads
	// ========================================
	always_comb begin
		case (idx_i)
			PIC_MASK_OFS:  rdat_o = {mask_q, 1'b0};        // bit 0 has no source
			PIC_EDGE_OFS:  rdat_o = {edge_sel_q, 1'b0};
			PIC_PEND_OFS:  rdat_o = {pend, 1'b0};
			PIC_CAUSE_OFS: rdat_o = dat_t'(cause_o);
			default:       rdat_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* logic/mpu_bus_route.sv */
`timescale 1ns/1ps
`default_nettype none

module mpu_bus_route (
	input  wire                            clk_i,
	input  wire                            arst_n_i,
	// from the page map stage
	input  wire                            s1_valid_i,
	output logic                           s1_ready_o,
	input  wire                            s1_wr_i,
	input  wire                            s1_fetch_i,
	input  wire  mpu_pkg::sel_t            s1_sel_i,
	input  wire  mpu_pkg::adr_t            s1_adr_i,
	input  wire  mpu_pkg::dat_t            s1_dat_i,
	// external bus
	output logic                           vpa_o,    // program fetch
	output logic                           vda_o,    // data cycle
	output logic                           wr_o,
	output mpu_pkg::sel_t                  sel_o,
	output mpu_pkg::adr_t                  adr_o,
	output mpu_pkg::dat_t                  dat_o,
	input  wire                            rdy_i,
	input  wire  mpu_pkg::dat_t            dat_i,
	// interrupt controller registers
	output logic                           pic_cs_o,
	output logic                           pic_wr_o,
	output logic [1:0]                     pic_idx_o,
	output mpu_pkg::dat_t                  pic_wdat_o,
	input  wire  mpu_pkg::dat_t            pic_rdat_i,
	// page map registers
	output logic                           map_we_o,
	output logic [mpu_pkg::MAP_IDX_W-1:0]  map_idx_o,
	output mpu_pkg::frame_t                map_wdat_o,
	input  wire  mpu_pkg::frame_t          map_rdat_i,
	// response to the core
	output logic                           rsp_valid_o,
	input  wire                            rsp_ready_i,
	output mpu_pkg::dat_t                  rsp_dat_o
);
	import mpu_pkg::*;

	route_state_e state_q;
	logic         take;        // stage 1 handoff this edge
	logic         hit_pic;
	logic         hit_map;
	logic         local_hit;   // served in one cycle
	logic         bus_start;
	logic         bus_done;
	dat_t         local_rdat;

	// ========================================
	// decode, physical address only
	// ========================================
	assign hit_pic   = (s1_adr_i[ADR_W-1 -: FRAME_W] == PIC_BASE);
	assign hit_map   = (s1_adr_i[ADR_W-1 -: FRAME_W] == MAP_BASE);
	assign local_hit = hit_pic | hit_map;

	assign s1_ready_o  = (state_q == RT_IDLE);   // busy or holding -> stall
	assign rsp_valid_o = (state_q == RT_RESP);
	assign take        = s1_valid_i & s1_ready_o;
	assign bus_start   = take & ~local_hit;
	assign bus_done    = (state_q == RT_BUS) & rdy_i;

	// local registers, word index from adr[..:2]
	assign pic_cs_o   = take & hit_pic;
	assign pic_wr_o   = s1_wr_i;
	assign pic_idx_o  = s1_adr_i[3:2];
	assign pic_wdat_o = s1_dat_i;
	assign map_we_o   = take & hit_map & s1_wr_i;
	assign map_idx_o  = s1_adr_i[MAP_IDX_W+1:2];
	assign map_wdat_o = s1_dat_i[FRAME_W-1:0];
	assign local_rdat = hit_pic ? pic_rdat_i : dat_t'(map_rdat_i);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= RT_IDLE;
		end else begin
			case (state_q)
				RT_IDLE: if (take) state_q <= local_hit ? RT_RESP : RT_BUS;
				RT_BUS:  if (rdy_i) state_q <= RT_RESP;
				RT_RESP: if (rsp_ready_i) state_q <= RT_IDLE;
				default: state_q <= RT_IDLE;
			endcase
		end
	end

	// ========================================
	// external cycle
	// ========================================
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			vpa_o <= 1'b0;
			vda_o <= 1'b0;
			wr_o  <= 1'b0;
		end else if (bus_start) begin
			vpa_o <= s1_fetch_i;
			vda_o <= ~s1_fetch_i;
			wr_o  <= s1_wr_i;
		end else if (bus_done) begin
			vpa_o <= 1'b0;   // cycle ends on the rdy edge
			vda_o <= 1'b0;
			wr_o  <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (bus_start) begin
			sel_o <= s1_sel_i;
			adr_o <= s1_adr_i;
			dat_o <= s1_dat_i;
		end
	end

	// writes answer with zero
	always_ff @(posedge clk_i) begin
		if (take && local_hit)
			rsp_dat_o <= s1_wr_i ? '0 : local_rdat;
		else if (bus_done)
			rsp_dat_o <= wr_o ? '0 : dat_i;
	end

	// one strobe at a time, and only while a bus cycle runs
	a_one_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!(vpa_o && vda_o) && ((vpa_o || vda_o) == (state_q == RT_BUS)));

	a_bus_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(state_q == RT_BUS && !rdy_i) |=>
			$stable({vpa_o, vda_o, wr_o, sel_o, adr_o, dat_o}));

endmodule

`default_nettype wire

/* logic/mpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mpu_top (
	input  wire                          clk_i,
	input  wire                          arst_n_i,
	input  wire  mpu_pkg::dat_t          pcr_i,
	// core request
	input  wire                          req_valid_i,
	output logic                         req_ready_o,
	input  wire                          req_wr_i,
	input  wire                          req_fetch_i,
	input  wire  mpu_pkg::sel_t          req_sel_i,
	input  wire  mpu_pkg::adr_t          req_adr_i,
	input  wire  mpu_pkg::dat_t          req_dat_i,
	// core response
	output logic                         rsp_valid_o,
	input  wire                          rsp_ready_i,
	output mpu_pkg::dat_t                rsp_dat_o,
	// external bus
	output logic                         vpa_o,
	output logic                         vda_o,
	output logic                         wr_o,
	output mpu_pkg::sel_t                sel_o,
	output mpu_pkg::adr_t                adr_o,
	output mpu_pkg::dat_t                dat_o,
	input  wire                          rdy_i,
	input  wire  mpu_pkg::dat_t          dat_i,
	// interrupts
	input  wire  [mpu_pkg::NUM_IRQ:1]    irq_lines_i,
	output logic                         irq_o,
	output mpu_pkg::cause_t              cause_o
);
	import mpu_pkg::*;

	// ========================================
	// stage 1 slot and local register ports
	// ========================================
	logic                 s1_valid;
	logic                 s1_ready;
	logic                 s1_wr;
	logic                 s1_fetch;
	sel_t                 s1_sel;
	adr_t                 s1_adr;    // already physical
	dat_t                 s1_dat;
	logic                 map_we;
	logic [MAP_IDX_W-1:0] map_idx;
	frame_t               map_wdat;
	frame_t               map_rdat;
	logic                 pic_cs;
	logic                 pic_wr;
	logic [1:0]           pic_idx;
	dat_t                 pic_wdat;
	dat_t                 pic_rdat;

	mpu_page_map u_map (
		.clk_i, .arst_n_i, .pcr_i,
		.req_valid_i, .req_ready_o, .req_wr_i, .req_fetch_i,
		.req_sel_i, .req_adr_i, .req_dat_i,
		.s1_valid_o(s1_valid), .s1_ready_i(s1_ready),
		.s1_wr_o(s1_wr), .s1_fetch_o(s1_fetch), .s1_sel_o(s1_sel),
		.s1_adr_o(s1_adr), .s1_dat_o(s1_dat),
		.map_we_i(map_we), .map_idx_i(map_idx),
		.map_wdat_i(map_wdat), .map_rdat_o(map_rdat)
	);

	mpu_bus_route u_route (
		.clk_i, .arst_n_i,
		.s1_valid_i(s1_valid), .s1_ready_o(s1_ready),
		.s1_wr_i(s1_wr), .s1_fetch_i(s1_fetch), .s1_sel_i(s1_sel),
		.s1_adr_i(s1_adr), .s1_dat_i(s1_dat),
		.vpa_o, .vda_o, .wr_o, .sel_o, .adr_o, .dat_o, .rdy_i, .dat_i,
		.pic_cs_o(pic_cs), .pic_wr_o(pic_wr), .pic_idx_o(pic_idx),
		.pic_wdat_o(pic_wdat), .pic_rdat_i(pic_rdat),
		.map_we_o(map_we), .map_idx_o(map_idx),
		.map_wdat_o(map_wdat), .map_rdat_i(map_rdat),
		.rsp_valid_o, .rsp_ready_i, .rsp_dat_o
	);

	mpu_pic u_pic (
		.clk_i, .arst_n_i, .irq_lines_i,
		.cs_i(pic_cs), .wr_i(pic_wr), .idx_i(pic_idx),
		.wdat_i(pic_wdat), .rdat_o(pic_rdat),
		.irq_o, .cause_o   // straight to the core
	);

endmodule

`default_nettype wire

/* verif/mpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mpu_checker (
	input  wire                    clk_i,
	input  wire                    arst_n_i,
	input  wire                    vpa_i,
	input  wire                    vda_i,
	input  wire                    wr_i,
	input  wire  mpu_pkg::sel_t    sel_i,
	input  wire  mpu_pkg::adr_t    adr_i,
	input  wire  mpu_pkg::dat_t    bus_dat_i,   // write data on the bus
	input  wire                    rdy_i,
	input  wire                    rsp_valid_i,
	input  wire                    rsp_ready_i,
	input  wire  mpu_pkg::dat_t    rsp_dat_i,
	input  wire                    irq_i,
	input  wire  mpu_pkg::cause_t  cause_i
);
	import mpu_pkg::*;

	logic [70:0] bus_q [$];   // {wr, vpa, vda, sel, adr, dat}
	dat_t        rsp_q [$];
	logic [9:0]  irq_q [$];   // {irq, cause}
	logic [70:0] exp_bus;
	logic [9:0]  exp_irq;
	int          checks   = 0;
	int          errors   = 0;
	int          tests    = 0;
	int          mark_chk = 0;   // counts at the start of the current test
	int          mark_err = 0;

	// ========================================
	// expectation queues
	// ========================================
	task automatic push_bus(input logic wr, input logic fetch, input sel_t sel,
			input adr_t adr, input dat_t dat);
		bus_q.push_back({wr, fetch, ~fetch, sel, adr, dat});
	endtask

	task automatic push_rsp(input dat_t dat);
		rsp_q.push_back(dat);
	endtask

	task automatic push_irq(input logic irq, input cause_t cause);
		irq_q.push_back({irq, cause});
	endtask

	function automatic bit idle();
		return bus_q.size() == 0 && rsp_q.size() == 0;
	endfunction

	task automatic compare(input string what, input dat_t got, input dat_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s expected %h, got %h", $time, what, exp, got);
		end
	endtask

	// ========================================
	// port monitor
	// ========================================
	always @(posedge clk_i) begin
		// bus cycle ends on the rdy edge
		if (arst_n_i && (vpa_i || vda_i) && rdy_i) begin
			if (bus_q.size() == 0) begin
				errors++;
				$display("extra bus cycle at %0t to address %h", $time, adr_i);
			end else begin
				exp_bus = bus_q.pop_front();
				compare("adr_o", adr_i, exp_bus[63:32]);
				compare("wr/vpa/vda", dat_t'({wr_i, vpa_i, vda_i}), dat_t'(exp_bus[70:68]));
				compare("sel_o", dat_t'(sel_i), dat_t'(exp_bus[67:64]));
				if (exp_bus[70])
					compare("dat_o", bus_dat_i, exp_bus[31:0]);   // only meaningful on writes
			end
		end
		if (arst_n_i && rsp_valid_i && rsp_ready_i) begin
			if (rsp_q.size() == 0) begin
				errors++;
				$display("response at %0t with no request outstanding", $time);
			end else
				compare("rsp_dat_o", rsp_dat_i, rsp_q.pop_front());
		end
		if (irq_q.size() != 0) begin
			exp_irq = irq_q.pop_front();
			compare("irq_o", dat_t'(irq_i), dat_t'(exp_irq[9]));
			compare("cause_o", dat_t'(cause_i), dat_t'(exp_irq[8:0]));
		end
	end

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %0d checks, %0d errors", tests, name,
			checks - mark_chk, errors - mark_err);
		mark_chk = checks;
		mark_err = errors;
	endtask

	function automatic bit passed();
		return errors == 0 && idle() && irq_q.size() == 0;
	endfunction

	task automatic report();
		if (!idle())
			$display("%0d bus cycles and %0d responses never arrived", bus_q.size(), rsp_q.size());
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
	endtask

endmodule

`default_nettype wire

/* verif/tb_mpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mpu;
	import mpu_pkg::*;

	// ~90 requests at about 12 cycles worst case plus irq settling, with margin
	localparam int   MAX_CYC = 4000;
	localparam dat_t BUS_XOR = 32'h5A5A_0000;   // bus model read pattern

	logic       clk_i       = 1'b0;
	logic       arst_n_i    = 1'b0;
	dat_t       pcr_i       = '0;
	logic       req_valid_i;
	logic       req_ready_o;
	logic       req_wr_i;
	logic       req_fetch_i;
	sel_t       req_sel_i;
	adr_t       req_adr_i;
	dat_t       req_dat_i;
	logic       rsp_valid_o;
	logic       rsp_ready_i = 1'b1;
	dat_t       rsp_dat_o;
	logic       vpa_o;
	logic       vda_o;
	logic       wr_o;
	sel_t       sel_o;
	adr_t       adr_o;
	dat_t       dat_o;
	logic       rdy_i       = 1'b0;
	dat_t       dat_i       = '0;
	logic [31:1] irq_lines_i;
	logic       irq_o;
	cause_t     cause_o;

	// reference mirrors, bit 0 of the controller words has no source
	frame_t      map_m [MAP_ENTRIES];
	logic [31:0] mask_m   = '0;
	logic [31:0] edge_m   = '0;
	logic [31:0] epend_m  = '0;
	logic [31:0] line_m   = '0;
	logic        rand_rdy = 1'b0;
	logic [1:0]  wait_cnt = '0;
	int          cyc      = 0;

	mpu_top dut0 (.*);

	mpu_checker u_chk (
		.clk_i, .arst_n_i, .vpa_i(vpa_o), .vda_i(vda_o), .wr_i(wr_o), .sel_i(sel_o),
		.adr_i(adr_o), .bus_dat_i(dat_o), .rdy_i, .rsp_valid_i(rsp_valid_o), .rsp_ready_i,
		.rsp_dat_i(rsp_dat_o), .irq_i(irq_o), .cause_i(cause_o)
	);

	always #20 clk_i = ~clk_i;   // 40 ns period

	// ========================================
	// bus and core response models
	// ========================================
	always @(posedge clk_i) begin
		if (rdy_i) begin
			rdy_i    <= 1'b0;                          // cycle closed on this edge
			wait_cnt <= 2'($urandom_range(3, 0));
		end else if (vpa_o || vda_o) begin
			if (wait_cnt == 2'd0) begin
				rdy_i <= 1'b1;
				dat_i <= adr_o ^ BUS_XOR;
			end else
				wait_cnt <= wait_cnt - 1'b1;
		end
	end

	always @(posedge clk_i)
		rsp_ready_i <= rand_rdy ? 1'($urandom_range(1, 0)) : 1'b1;

	always @(posedge clk_i) begin
		cyc <= cyc + 1;
		if (cyc == MAX_CYC) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cyc);
			$display("Verification failed");
			$finish;
		end
	end

	// ========================================
	// reference model
	// ========================================
	function automatic cause_t ref_cause();
		logic [31:0] act;
		act = ((edge_m & epend_m) | (~edge_m & line_m)) & mask_m;
		for (int i = 1; i < 32; i++)
			if (act[i]) return cause_t'(i);   // lowest source wins
		return '0;
	endfunction

	function automatic adr_t phys(input adr_t va);
		return pcr_i[31] ? {map_m[va[31:28]], va[15:0]} : va;
	endfunction

	function automatic dat_t ref_read(input adr_t pa);
		if (pa[31:16] == PIC_BASE) begin
			case (pa[3:2])
				PIC_MASK_OFS: return mask_m;
				PIC_EDGE_OFS: return edge_m;
				PIC_PEND_OFS: return (edge_m & epend_m) | (~edge_m & line_m);
				default:      return dat_t'(ref_cause());
			endcase
		end
		if (pa[31:16] == MAP_BASE)
			return dat_t'(map_m[pa[5:2]]);
		return pa ^ BUS_XOR;
	endfunction

	function automatic adr_t pic_adr(input logic [1:0] ofs);
		return {PIC_BASE, 12'h000, ofs, 2'b00};
	endfunction

	function automatic adr_t map_adr(input logic [3:0] idx);
		return {MAP_BASE, 10'h000, idx, 2'b00};
	endfunction

	function automatic adr_t ext_adr();
		return {4'($urandom_range(13, 0)), 26'($urandom()), 2'b00};   // stays off the windows
	endfunction

	// ========================================
	// core model
	// ========================================
	// called on a rising edge, returns on the accepting edge
	task automatic send(input logic wr, input logic fetch, input adr_t va, input dat_t dat);
		adr_t pa;
		sel_t sel;
		pa  = phys(va);
		sel = sel_t'($urandom_range(15, 1));
		if (pa[31:16] != PIC_BASE && pa[31:16] != MAP_BASE)
			u_chk.push_bus(wr, fetch, sel, pa, dat);
		u_chk.push_rsp(wr ? '0 : ref_read(pa));
		if (wr && pa[31:16] == MAP_BASE)
			map_m[pa[5:2]] = dat[15:0];
		if (wr && pa[31:16] == PIC_BASE) begin
			case (pa[3:2])
				PIC_MASK_OFS: mask_m  = dat & 32'hFFFF_FFFE;
				PIC_EDGE_OFS: edge_m  = dat & 32'hFFFF_FFFE;
				PIC_PEND_OFS: epend_m = epend_m & ~dat;   // write one to clear
				default: ;
			endcase
		end
		req_valid_i <= 1'b1;
		req_wr_i    <= wr;
		req_fetch_i <= fetch;
		req_sel_i   <= sel;
		req_adr_i   <= va;
		req_dat_i   <= dat;
		do @(posedge clk_i); while (!req_ready_o);
	endtask

	task automatic drain();
		req_valid_i <= 1'b0;
		while (!u_chk.idle()) @(posedge clk_i);
	endtask

	task automatic drive_lines(input logic [31:0] v);
		irq_lines_i <= v[31:1];
		line_m = v & 32'hFFFF_FFFE;
	endtask

	task automatic pulse(input logic [31:0] bits);
		drive_lines(line_m | bits);
		@(posedge clk_i);
		drive_lines(line_m & ~bits);
		epend_m = epend_m | (bits & edge_m);
	endtask

	// sync chain plus output register settle well inside 6 cycles
	task automatic check_irq();
		repeat (6) @(posedge clk_i);
		@(negedge clk_i);
		u_chk.push_irq(ref_cause() != '0, ref_cause());
		@(posedge clk_i);
	endtask

	// ========================================
	// tests
	// ========================================
	initial begin
		logic wr;
		void'($urandom(51));
		req_valid_i <= 1'b0;
		req_wr_i    <= 1'b0;
		req_fetch_i <= 1'b0;
		req_sel_i   <= '0;
		req_adr_i   <= '0;
		req_dat_i   <= '0;
		irq_lines_i <= '0;
		for (int i = 0; i < MAP_ENTRIES; i++)
			map_m[i] = frame_t'(i << 12);   // identity after reset
		repeat (2) @(posedge clk_i);
		arst_n_i <= 1'b1;
		@(posedge clk_i);

		repeat (12) begin
			wr = 1'($urandom_range(1, 0));
			send(wr, !wr && $urandom_range(1, 0) == 1, ext_adr(), $urandom());
		end
		drain();
		u_chk.end_test("external bus, paging off");

		for (int i = 1; i < 4; i++)
			send(1'b1, 1'b0, map_adr(4'(i)), {16'h0, 4'h3, 12'($urandom())});
		for (int i = 1; i < 4; i++)
			send(1'b0, 1'b0, map_adr(4'(i)), '0);
		drain();
		pcr_i <= 32'h8000_0000;   // paging on from here
		@(posedge clk_i);
		repeat (8) begin
			wr = 1'($urandom_range(1, 0));
			send(wr, 1'b0, {4'($urandom_range(3, 1)), 26'($urandom()), 2'b00}, $urandom());
		end
		drain();
		u_chk.end_test("page map translation");

		send(1'b1, 1'b0, pic_adr(PIC_EDGE_OFS), 32'h0000_0220);   // sources 5 and 9
		send(1'b1, 1'b0, pic_adr(PIC_MASK_OFS), 32'h0000_0220);
		drain();
		pulse(32'h0000_0220);
		check_irq();
		send(1'b1, 1'b0, pic_adr(PIC_PEND_OFS), 32'h0000_0020);
		drain();
		check_irq();
		send(1'b1, 1'b0, pic_adr(PIC_PEND_OFS), 32'h0000_0200);
		drain();
		check_irq();
		u_chk.end_test("edge sources");

		send(1'b1, 1'b0, pic_adr(PIC_MASK_OFS), 32'h0000_1220);   // level 12 on, 20 stays off
		drain();
		drive_lines(32'h0010_0000);
		check_irq();
		drive_lines(32'h0010_1000);
		check_irq();
		send(1'b0, 1'b0, pic_adr(PIC_PEND_OFS), '0);
		drain();
		drive_lines(32'h0010_0000);
		check_irq();
		drive_lines('0);
		u_chk.end_test("level sources");

		rand_rdy <= 1'b1;
		repeat (40) begin
			wr = 1'($urandom_range(1, 0));
			if ($urandom_range(7, 0) == 0)
				send(1'b0, 1'b0, map_adr(4'($urandom())), '0);
			else
				send(wr, !wr && $urandom_range(1, 0) == 1, ext_adr(), $urandom());
		end
		drain();
		rand_rdy <= 1'b0;
		u_chk.end_test("back to back with stalls");

		send(1'b1, 1'b0, pic_adr(PIC_MASK_OFS), $urandom());
		send(1'b0, 1'b0, pic_adr(PIC_MASK_OFS), '0);
		send(1'b1, 1'b0, pic_adr(PIC_EDGE_OFS), $urandom());
		send(1'b0, 1'b0, pic_adr(PIC_EDGE_OFS), '0);
		drain();
		u_chk.end_test("controller readback");

		u_chk.report();
		if (u_chk.passed())
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
logic/mpu_pkg.sv
logic/mpu_page_map.sv
logic/mpu_pic.sv
logic/mpu_bus_route.sv
logic/mpu_top.sv
verif/mpu_checker.sv
verif/tb_mpu.sv

/* Makefile */
# Verilator build and run of the mpu testbench

VERILATOR ?= verilator
TOP       ?= tb_mpu
FLIST     ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "Verification passed" $(LOG); then \
		echo "test target passed"; \
	else \
		echo "test target failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
